/* files.f */
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/bypassIf.sv
design/fetchStage.sv
design/registerFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/cpuTop.sv
tests/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= cpuTb
RTL_TOP   ?= cpuTop
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module cpuTb;

    localparam int memWords     = 256;
    localparam int clockHalf    = 10;
    localparam int resetCycles  = 8;
    localparam int driveDelay   = 2;
    localparam int storeTimeout = 2000;
    localparam int drainCycles  = 10;
    localparam int refStepLimit = 1000;

    // Opcodes of the RV32I subset
    localparam logic [6:0] opcodeReg    = 7'b0110011;
    localparam logic [6:0] opcodeImm    = 7'b0010011;
    localparam logic [6:0] opcodeLui    = 7'b0110111;
    localparam logic [6:0] opcodeLoad   = 7'b0000011;
    localparam logic [6:0] opcodeStore  = 7'b0100011;
    localparam logic [6:0] opcodeBranch = 7'b1100011;
    localparam logic [6:0] opcodeJal    = 7'b1101111;

    logic             iCLK;
    logic             iRST;
    logic [`XLEN-1:0] instrAddr, instrData;
    logic [`XLEN-1:0] dataAddr, dataWriteData, dataReadData;
    logic             dataWriteEnable;

    logic [31:0] instrMem [0:memWords-1];
    logic [31:0] dataMem  [0:memWords-1];
    logic [31:0] dataInit [0:memWords-1];   // Image loaded while reset is held

    logic [15:0] lfsrState;
    int          progLen;
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] wantAddr, wantData;
    logic [31:0] parkPc;
    int          cyclesSinceReset = 0;
    int          waitCycles;
    int          valueErrors   = 0;
    int          strayErrors   = 0;
    int          earlyErrors   = 0;
    int          timeoutErrors = 0;
    int          pcErrors      = 0;

    cpuTop uut (
        .iCLK            (iCLK),
        .iRST            (iRST),
        .instrAddr       (instrAddr),
        .instrData       (instrData),
        .dataAddr        (dataAddr),
        .dataWriteData   (dataWriteData),
        .dataWriteEnable (dataWriteEnable),
        .dataReadData    (dataReadData)
    );

    // ************************************************************************
    // Memory models that both read combinationally

    assign instrData    = instrMem[instrAddr[9:2]];
    assign dataReadData = dataMem[dataAddr[9:2]];

    always @(posedge iCLK) begin
        if (iRST) begin
            for (int i = 0; i < memWords; i++)
                dataMem[i[7:0]] <= dataInit[i[7:0]];
        end else if (dataWriteEnable) begin
            dataMem[dataAddr[9:2]] <= dataWriteData;
        end
    end

    initial begin
        iCLK = 1'b0;
        forever #clockHalf iCLK = ~iCLK;
    end

    // ************************************************************************
    // Random source and instruction encoders

    function automatic logic [15:0] lfsrNext(logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);    // One step per bit
        end
    endtask

    function automatic logic [31:0] rType(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opcodeReg};
    endfunction

    function automatic logic [31:0] iType(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sType(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcodeStore};
    endfunction

    function automatic logic [31:0] bType(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcodeBranch};
    endfunction

    function automatic logic [31:0] jType(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcodeJal};
    endfunction

    function automatic logic [31:0] uType(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, opcodeLui};
    endfunction

    task automatic emit(input logic [31:0] instr);
        instrMem[progLen[7:0]] = instr;
        progLen++;
    endtask

    task automatic fillMemories();
        logic [31:0] word;
        lfsrState = 16'd60;
        for (int i = 0; i < memWords; i++) begin
            instrMem[i[7:0]] = {17'd0, i[7:0], 7'h7F};     // Unknown opcode that acts as a nop
            dataInit[i[7:0]] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, ~i[7:0] ^ 8'hC3};
        end
        for (int i = 0; i < 4; i++) begin
            drawBits(32, word);
            dataInit[8'd128 + i[7:0]] = word;   // Load source at 0x200
        end
    endtask

    task automatic assembleProgram();
        logic [31:0] imm1, imm2, imm3, imm5, upper;
        drawBits(12, imm1);
        drawBits(12, imm2);
        drawBits(12, imm3);
        drawBits(20, upper);
        drawBits(12, imm5);
        progLen = 0;
        emit(sType(5'd0, 5'd0, 12'h0FC));       // Earliest possible store
        // Dependent ALU chain
        emit(iType(opcodeImm, 3'b000, 5'd10, 5'd0, 12'h100));    // Store area base
        emit(iType(opcodeImm, 3'b000, 5'd1, 5'd0, imm1[11:0]));
        emit(iType(opcodeImm, 3'b000, 5'd2, 5'd1, imm2[11:0]));
        emit(rType(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(rType(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        emit(rType(7'h00, 3'b111, 5'd5, 5'd4, 5'd2));
        emit(rType(7'h00, 3'b110, 5'd6, 5'd5, 5'd3));
        emit(rType(7'h00, 3'b010, 5'd7, 5'd4, 5'd6));
        emit(uType(5'd8, upper[19:0]));
        emit(iType(opcodeImm, 3'b000, 5'd8, 5'd8, imm3[11:0]));
        emit(iType(opcodeImm, 3'b000, 5'd9, 5'd8, 12'd5));
        emit(sType(5'd9, 5'd10, 12'd24));       // Store data from MEM
        emit(sType(5'd3, 5'd10, 12'd0));
        emit(sType(5'd4, 5'd10, 12'd4));
        emit(sType(5'd5, 5'd10, 12'd8));
        emit(sType(5'd6, 5'd10, 12'd12));
        emit(sType(5'd7, 5'd10, 12'd16));
        emit(sType(5'd8, 5'd10, 12'd20));
        // Load-use
        emit(iType(opcodeImm, 3'b000, 5'd11, 5'd0, 12'h200));
        emit(iType(opcodeLoad, 3'b010, 5'd12, 5'd11, 12'd0));
        emit(rType(7'h00, 3'b000, 5'd13, 5'd12, 5'd1));
        emit(sType(5'd13, 5'd10, 12'd28));
        emit(iType(opcodeLoad, 3'b010, 5'd14, 5'd11, 12'd4));
        emit(sType(5'd14, 5'd10, 12'd32));
        // Branches on fresh operands
        emit(iType(opcodeImm, 3'b000, 5'd15, 5'd12, 12'd0));
        emit(bType(3'b000, 5'd15, 5'd12, 13'd8));    // Taken after a stall on x15
        emit(sType(5'd1, 5'd10, 12'd36));
        emit(iType(opcodeImm, 3'b000, 5'd19, 5'd12, 12'd0));
        emit(bType(3'b001, 5'd19, 5'd12, 13'd8));    // Not taken
        emit(sType(5'd2, 5'd10, 12'd40));
        emit(iType(opcodeImm, 3'b000, 5'd16, 5'd0, 12'd1));
        emit(bType(3'b001, 5'd16, 5'd0, 13'd8));
        emit(sType(5'd3, 5'd10, 12'd44));
        emit(iType(opcodeImm, 3'b000, 5'd18, 5'd0, 12'd3));
        emit(bType(3'b000, 5'd18, 5'd0, 13'd8));
        emit(sType(5'd18, 5'd10, 12'd48));
        emit(iType(opcodeLoad, 3'b010, 5'd17, 5'd11, 12'd0));
        emit(bType(3'b000, 5'd17, 5'd12, 13'd8));    // Load in EX
        emit(sType(5'd4, 5'd10, 12'd52));
        emit(sType(5'd17, 5'd10, 12'd56));
        // Link and flush
        emit(jType(5'd20, 21'd8));
        emit(sType(5'd1, 5'd10, 12'd60));
        emit(sType(5'd20, 5'd10, 12'd64));
        emit(32'hFFFF_FFFF);
        // Writes to x0 are lost
        emit(iType(opcodeImm, 3'b000, 5'd0, 5'd1, imm5[11:0]));
        emit(rType(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));
        emit(iType(opcodeLoad, 3'b010, 5'd0, 5'd11, 12'd0));
        emit(sType(5'd0, 5'd10, 12'd68));
        emit(jType(5'd0, 21'd0));       // Park
    endtask

    // ************************************************************************
    // Architectural reference stepping one instruction at a time

    function automatic void refRun();
        logic [31:0] regs [0:31];
        logic [31:0] mem  [0:memWords-1];
        logic [31:0] pc, nextPc, instr, a, b, addr;
        logic [31:0] immI, immS, immB, immJ;
        logic [6:0]  opc, f7;
        logic [4:0]  rd;
        logic [2:0]  f3;
        int          steps;
        mem = dataInit;
        for (int r = 0; r < 32; r++)
            regs[r[4:0]] = '0;
        pc    = `RESET_PC;
        steps = 0;
        while (steps < refStepLimit) begin
            instr  = instrMem[pc[9:2]];
            opc    = instr[6:0];
            rd     = instr[11:7];
            f3     = instr[14:12];
            f7     = instr[31:25];
            a      = regs[instr[19:15]];
            b      = regs[instr[24:20]];
            immI   = {{20{instr[31]}}, instr[31:20]};
            immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            nextPc = pc + 32'd4;
            case (opc)
                opcodeReg: begin
                    case ({f7, f3})
                        {7'h00, 3'b000}: regs[rd] = a + b;
                        {7'h20, 3'b000}: regs[rd] = a - b;
                        {7'h00, 3'b010}: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        {7'h00, 3'b110}: regs[rd] = a | b;
                        {7'h00, 3'b111}: regs[rd] = a & b;
                        default: ;
                    endcase
                end
                opcodeImm: begin
                    if (f3 == 3'b000)
                        regs[rd] = a + immI;
                end
                opcodeLui: regs[rd] = {instr[31:12], 12'd0};
                opcodeLoad: begin
                    if (f3 == 3'b010) begin
                        addr     = a + immI;
                        regs[rd] = mem[addr[9:2]];
                    end
                end
                opcodeStore: begin
                    if (f3 == 3'b010) begin
                        addr           = a + immS;
                        mem[addr[9:2]] = b;
                        expAddr.push_back(addr);
                        expData.push_back(b);
                    end
                end
                opcodeBranch: begin
                    if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
                        nextPc = pc + immB;
                end
                opcodeJal: begin
                    regs[rd] = pc + 32'd4;
                    nextPc   = pc + immJ;
                end
                default: ;      // Unknown encodings change nothing
            endcase
            regs[0] = '0;
            if (nextPc == pc)
                break;          // Self loop ends the program
            pc = nextPc;
            steps++;
        end
        parkPc = pc;
    endfunction

    // ************************************************************************
    // Store checking

    always @(posedge iCLK) begin
        if (iRST)
            cyclesSinceReset <= 0;
        else
            cyclesSinceReset <= cyclesSinceReset + 1;
    end

    // Fetch starts from the reset address
    always @(negedge iCLK) begin
        if (cyclesSinceReset == 0) begin
            assert (instrAddr == `RESET_PC)
            else begin
                pcErrors++;
                $display("FAIL t=%0t instrAddr expected %h got %h",
                         $time, `RESET_PC, instrAddr);
            end
        end
    end

    always @(negedge iCLK) begin
        assert (!(dataWriteEnable && (iRST || cyclesSinceReset < 3)))
        else begin
            earlyErrors++;
            $display("Data write enable was high during reset or too soon after it at %0t",
                     $time);
        end
    end

    always @(negedge iCLK) begin
        if (!iRST && dataWriteEnable) begin
            assert (expAddr.size() != 0)
            else begin
                strayErrors++;
                $display("Store to address %h at %0t was not expected by the reference",
                         dataAddr, $time);
            end
            if (expAddr.size() != 0) begin
                wantAddr = expAddr.pop_front();
                wantData = expData.pop_front();
                assert (dataAddr == wantAddr)
                else begin
                    valueErrors++;
                    $display("FAIL t=%0t dataAddr expected %h got %h",
                             $time, wantAddr, dataAddr);
                end
                assert (dataWriteData == wantData)
                else begin
                    valueErrors++;
                    $display("FAIL t=%0t dataWriteData expected %h got %h",
                             $time, wantData, dataWriteData);
                end
            end
        end
    end

    initial begin
        iRST = 1'b1;
        fillMemories();
        assembleProgram();
        refRun();
        repeat (resetCycles) @(posedge iCLK);
        #driveDelay iRST = 1'b0;
        waitCycles = 0;
        while (expAddr.size() != 0 && waitCycles < storeTimeout) begin
            @(posedge iCLK);
            waitCycles++;
        end
        assert (expAddr.size() == 0)
        else begin
            timeoutErrors++;
            $display("Timed out after %0d cycles with %0d expected stores never seen",
                     waitCycles, expAddr.size());
        end
        repeat (drainCycles) @(posedge iCLK);   // Catch late stray stores
        #driveDelay;
        // Parked jal alternates with its flushed fall-through fetch
        assert (instrAddr == parkPc || instrAddr == parkPc + 32'd4)
        else begin
            pcErrors++;
            $display("FAIL t=%0t instrAddr expected %h or %h got %h",
                     $time, parkPc, parkPc + 32'd4, instrAddr);
        end
        $display("Errors: %0d value, %0d stray store, %0d early store, %0d timeout, %0d fetch",
                 valueErrors, strayErrors, earlyErrors, timeoutErrors, pcErrors);
        if (valueErrors + strayErrors + earlyErrors + timeoutErrors + pcErrors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* design/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module cpuTop (
    input  logic             iCLK,
    input  logic             iRST,
    output logic [`XLEN-1:0] instrAddr,
    input  logic [`XLEN-1:0] instrData,
    output logic [`XLEN-1:0] dataAddr,
    output logic [`XLEN-1:0] dataWriteData,
    output logic             dataWriteEnable,
    input  logic [`XLEN-1:0] dataReadData
);

    import pipePkg::*;

    ifIdT             ifId;
    idExT             idEx;
    exMemT            exMem;
    logic             stall;
    logic             redirect;
    logic [`XLEN-1:0] redirectPc;

    bypassIf bypass ();

    fetchStage fetch (
        .iCLK       (iCLK),
        .iRST       (iRST),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instrAddr  (instrAddr),
        .instrData  (instrData),
        .ifId       (ifId)
    );

    decodeStage decode (
        .iCLK       (iCLK),
        .iRST       (iRST),
        .ifId       (ifId),
        .bypass     (bypass.decodeSink),
        .bypassWb   (bypass.wbSrc),     // Register file write port
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .idEx       (idEx)
    );

    executeStage execute (
        .iCLK     (iCLK),
        .iRST     (iRST),
        .idEx     (idEx),
        .bypass   (bypass.executeSink),
        .bypassEx (bypass.exSrc),
        .exMem    (exMem)
    );

    memoryStage memory (
        .iCLK            (iCLK),
        .iRST            (iRST),
        .exMem           (exMem),
        .dataAddr        (dataAddr),
        .dataWriteData   (dataWriteData),
        .dataWriteEnable (dataWriteEnable),
        .dataReadData    (dataReadData),
        .bypassMem       (bypass.memSrc),
        .bypassWb        (bypass.wbSrc)
    );

endmodule

`default_nettype wire

/* design/memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module memoryStage (
    input  logic             iCLK,
    input  logic             iRST,
    input  pipePkg::exMemT   exMem,
    output logic [`XLEN-1:0] dataAddr,
    output logic [`XLEN-1:0] dataWriteData,
    output logic             dataWriteEnable,
    input  logic [`XLEN-1:0] dataReadData,
    bypassIf.memSrc          bypassMem,
    bypassIf.wbSrc           bypassWb
);

    import isaPkg::*;

    wbSelT                  wbSel;
    logic [`XLEN-1:0]       wbValue;
    logic [`REG_ADDR_W-1:0] wbRd;
    logic                   wbRegWrite;
    logic [`XLEN-1:0]       wbData;

    // Full-word accesses with the store landing at the next edge
    assign dataAddr        = exMem.aluResult;
    assign dataWriteData   = exMem.storeData;
    assign dataWriteEnable = exMem.memWrite;

    assign wbSel = exMem.memRead ? wbLoad : wbAlu;

    always_comb begin
        case (wbSel)
            wbLoad:  wbValue = dataReadData;
            default: wbValue = exMem.aluResult;
        endcase
    end

    assign bypassMem.memRd       = exMem.rd;
    assign bypassMem.memRegWrite = exMem.regWrite;
    assign bypassMem.memData     = wbValue;

    // ************************************************************************
    // MEM/WB register

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST)
            wbRegWrite <= 1'b0;
        else
            wbRegWrite <= exMem.regWrite;
    end

    always_ff @(posedge iCLK) begin
        wbRd   <= exMem.rd;
        wbData <= wbValue;
    end

    assign bypassWb.wbRd       = wbRd;
    assign bypassWb.wbRegWrite = wbRegWrite;
    assign bypassWb.wbData     = wbData;

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module executeStage (
    input  logic           iCLK,
    input  logic           iRST,
    input  pipePkg::idExT  idEx,
    bypassIf.executeSink   bypass,
    bypassIf.exSrc         bypassEx,
    output pipePkg::exMemT exMem
);

    import isaPkg::*;

    logic [`XLEN-1:0] opA, rs2Fwd, opB;
    logic [`XLEN-1:0] aluResult, exResult;

    // Seen by decode for load-use and branch stalls
    assign bypassEx.exRd       = idEx.rd;
    assign bypassEx.exRegWrite = idEx.regWrite;
    assign bypassEx.exMemRead  = idEx.memRead;

    assign opA = (bypass.memRegWrite && bypass.memRd == idEx.rs1Addr) ? bypass.memData :
                 (bypass.wbRegWrite && bypass.wbRd == idEx.rs1Addr)   ? bypass.wbData :
                 idEx.rs1Val;
    assign rs2Fwd = (bypass.memRegWrite && bypass.memRd == idEx.rs2Addr) ? bypass.memData :
                    (bypass.wbRegWrite && bypass.wbRd == idEx.rs2Addr)   ? bypass.wbData :
                    idEx.rs2Val;
    assign opB = idEx.useImm ? idEx.imm : rs2Fwd;

    always_comb begin
        case (idEx.aluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluAnd:   aluResult = opA & opB;
            aluOr:    aluResult = opA | opB;
            aluSlt:   aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluPassB: aluResult = opB;      // lui
            default:  aluResult = '0;
        endcase
    end

    assign exResult = idEx.isLink ? idEx.pcPlus4 : aluResult;

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST)
            exMem <= '0;
        else
            exMem <= '{aluResult: exResult, storeData: rs2Fwd, rd: idEx.rd,
                       memRead: idEx.memRead, memWrite: idEx.memWrite,
                       regWrite: idEx.regWrite};
    end

    // The decoder never marks an access as both load and store
    loadStoreExclusive: assert property (
        @(posedge iCLK) disable iff (iRST) !(idEx.memRead && idEx.memWrite));

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module decodeStage (
    input  logic               iCLK,
    input  logic               iRST,
    input  pipePkg::ifIdT      ifId,
    bypassIf.decodeSink        bypass,
    bypassIf.wbSrc             bypassWb,
    output logic               stall,
    output logic               redirect,
    output logic [`XLEN-1:0]   redirectPc,
    output pipePkg::idExT      idEx
);

    import isaPkg::*;

    opcodeT                 opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs1Addr, rs2Addr, rd;
    logic [`XLEN-1:0]       rs1Data, rs2Data, rs1Fwd, rs2Fwd;
    logic [`XLEN-1:0]       immI, immS, immB, immJ, immU, imm;
    aluOpT                  aluOp;
    logic                   useImm, isLink, memRead, memWrite, rfWrite;
    logic                   isBranch, isJal, usesRs1, usesRs2;
    logic                   exMatch1, exMatch2, branchTaken;

    // ************************************************************************
    // Field extraction and immediates

    assign opcode  = opcodeT'(ifId.instr[6:0]);
    assign funct3  = ifId.instr[14:12];
    assign funct7  = ifId.instr[31:25];
    assign rd      = ifId.instr[11:7];
    assign rs1Addr = ifId.instr[19:15];
    assign rs2Addr = ifId.instr[24:20];

    assign immI = {{20{ifId.instr[31]}}, ifId.instr[31:20]};
    assign immS = {{20{ifId.instr[31]}}, ifId.instr[31:25], ifId.instr[11:7]};
    assign immB = {{19{ifId.instr[31]}}, ifId.instr[31], ifId.instr[7],
                   ifId.instr[30:25], ifId.instr[11:8], 1'b0};
    assign immJ = {{11{ifId.instr[31]}}, ifId.instr[31], ifId.instr[19:12],
                   ifId.instr[20], ifId.instr[30:21], 1'b0};
    assign immU = {ifId.instr[31:12], 12'b0};

    // Unknown encodings fall through with all flags low
    always_comb begin
        aluOp    = aluAdd;
        imm      = immI;
        useImm   = 1'b0;
        isLink   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        rfWrite  = 1'b0;
        isBranch = 1'b0;
        isJal    = 1'b0;
        usesRs1  = 1'b0;
        usesRs2  = 1'b0;
        case (opcode)
            opcOp: begin
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                rfWrite = (funct7 == f7Base) || (funct7 == f7Sub && funct3 == f3AddSub);
                case (funct3)
                    f3AddSub: aluOp = (funct7 == f7Sub) ? aluSub : aluAdd;
                    f3Slt:    aluOp = aluSlt;
                    f3Or:     aluOp = aluOr;
                    f3And:    aluOp = aluAnd;
                    default:  rfWrite = 1'b0;
                endcase
            end
            opcOpImm: if (funct3 == f3AddSub) begin    // addi only
                usesRs1 = 1'b1;
                useImm  = 1'b1;
                rfWrite = 1'b1;
            end
            opcLui: begin
                aluOp   = aluPassB;
                imm     = immU;
                useImm  = 1'b1;
                rfWrite = 1'b1;
            end
            opcLoad: if (funct3 == f3Word) begin
                usesRs1 = 1'b1;
                useImm  = 1'b1;
                memRead = 1'b1;
                rfWrite = 1'b1;
            end
            opcStore: if (funct3 == f3Word) begin
                usesRs1  = 1'b1;
                usesRs2  = 1'b1;
                imm      = immS;
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            opcBranch: if (funct3 == f3Beq || funct3 == f3Bne) begin
                usesRs1  = 1'b1;
                usesRs2  = 1'b1;
                imm      = immB;
                isBranch = 1'b1;
            end
            opcJal: begin
                imm     = immJ;
                isJal   = 1'b1;
                isLink  = 1'b1;
                rfWrite = 1'b1;
            end
            default: ;
        endcase
    end

    registerFile regFile (
        .iCLK     (iCLK),
        .iRST     (iRST),
        .rs1Addr  (rs1Addr),
        .rs2Addr  (rs2Addr),
        .wrAddr   (bypassWb.wbRd),
        .wrEnable (bypassWb.wbRegWrite),
        .wrData   (bypassWb.wbData),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data)
    );

    // ************************************************************************
    // Branch resolution and hazards

    // WB values reach ID through the register file write-through
    assign rs1Fwd = (bypass.memRegWrite && bypass.memRd == rs1Addr) ? bypass.memData : rs1Data;
    assign rs2Fwd = (bypass.memRegWrite && bypass.memRd == rs2Addr) ? bypass.memData : rs2Data;

    assign branchTaken = isBranch && ((rs1Fwd == rs2Fwd) ^ (funct3 == f3Bne));

    // regWrite already implies rd != x0
    assign exMatch1 = usesRs1 && bypass.exRegWrite && bypass.exRd == rs1Addr;
    assign exMatch2 = usesRs2 && bypass.exRegWrite && bypass.exRd == rs2Addr;

    assign stall      = (exMatch1 || exMatch2) && (bypass.exMemRead || isBranch);
    assign redirect   = !stall && (isJal || branchTaken);
    assign redirectPc = ifId.pc + imm;

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST)
            idEx <= '0;
        else if (stall)
            idEx <= '0;     // Bubble
        else
            idEx <= '{pcPlus4: ifId.pc + `XLEN'd4, rs1Val: rs1Data, rs2Val: rs2Data,
                      rs1Addr: rs1Addr, rs2Addr: rs2Addr, rd: rd, imm: imm,
                      aluOp: aluOp, useImm: useImm, isLink: isLink,
                      memRead: memRead, memWrite: memWrite,
                      regWrite: rfWrite && (rd != '0)};
    end

endmodule

`default_nettype wire

/* design/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module registerFile (
    input  logic                   iCLK,
    input  logic                   iRST,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    input  logic [`REG_ADDR_W-1:0] wrAddr,
    input  logic                   wrEnable,
    input  logic [`XLEN-1:0]       wrData,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data
);

    logic [`XLEN-1:0] regs [1:31];     // x0 has no storage

    always_ff @(posedge iCLK) begin
        if (wrEnable && wrAddr != '0)
            regs[wrAddr] <= wrData;
    end

    // Write-through so WB and ID can share a cycle
    assign rs1Data = (rs1Addr == '0) ? '0 :
                     (wrEnable && wrAddr == rs1Addr) ? wrData : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 :
                     (wrEnable && wrAddr == rs2Addr) ? wrData : regs[rs2Addr];

    // Decode drops regWrite for rd == x0, so nothing reaches here for x0
    noWriteToZero: assert property (
        @(posedge iCLK) disable iff (iRST) !(wrEnable && wrAddr == '0));

endmodule

`default_nettype wire

/* design/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module fetchStage (
    input  logic             iCLK,
    input  logic             iRST,
    input  logic             stall,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirectPc,
    output logic [`XLEN-1:0] instrAddr,
    input  logic [`XLEN-1:0] instrData,
    output pipePkg::ifIdT    ifId
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] nextPc;

    assign nextPc    = redirect ? redirectPc : pc + `XLEN'd4;
    assign instrAddr = pc;      // Instruction bus answers in the same cycle

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            pc   <= `RESET_PC;
            ifId <= '{pc: `RESET_PC, instr: `NOP_INSTR};
        end else begin
            if (!stall)
                pc <= nextPc;
            if (redirect)
                ifId <= '{pc: pc, instr: `NOP_INSTR};   // Squash wrong-path fetch
            else if (!stall)
                ifId <= '{pc: pc, instr: instrData};
        end
    end

    // Decode only redirects once its operands are settled
    stallRedirectExclusive: assert property (
        @(posedge iCLK) disable iff (iRST) !(stall && redirect));

endmodule

`default_nettype wire

/* design/bypassIf.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

interface bypassIf;

    // Instruction in EX as seen by the hazard logic
    logic [`REG_ADDR_W-1:0] exRd;
    logic                   exRegWrite;
    logic                   exMemRead;

    // MEM stage write-back value with load data already selected
    logic [`REG_ADDR_W-1:0] memRd;
    logic                   memRegWrite;
    logic [`XLEN-1:0]       memData;

    // MEM/WB register that also feeds the register file write port
    logic [`REG_ADDR_W-1:0] wbRd;
    logic                   wbRegWrite;
    logic [`XLEN-1:0]       wbData;

    modport exSrc       (output exRd, exRegWrite, exMemRead);
    modport memSrc      (output memRd, memRegWrite, memData);
    modport wbSrc       (output wbRd, wbRegWrite, wbData);
    modport decodeSink  (input exRd, exRegWrite, exMemRead,
                         input memRd, memRegWrite, memData,
                         input wbRd, wbRegWrite, wbData);
    modport executeSink (input memRd, memRegWrite, memData,
                         input wbRd, wbRegWrite, wbData);

endinterface

`default_nettype wire

/* design/pipePkg.sv */
`default_nettype none
`include "rv_consts.svh"

package pipePkg;

    // IF/ID register
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
    } ifIdT;

    // ID/EX register
    typedef struct packed {
        logic [`XLEN-1:0]       pcPlus4;
        logic [`XLEN-1:0]       rs1Val;
        logic [`XLEN-1:0]       rs2Val;
        logic [`REG_ADDR_W-1:0] rs1Addr;
        logic [`REG_ADDR_W-1:0] rs2Addr;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;
        isaPkg::aluOpT          aluOp;
        logic                   useImm;     // Operand B from immediate
        logic                   isLink;     // Result is pc+4 (jal)
        logic                   memRead;
        logic                   memWrite;
        logic                   regWrite;
    } idExT;

    // EX/MEM register
    typedef struct packed {
        logic [`XLEN-1:0]       aluResult;
        logic [`XLEN-1:0]       storeData;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   memRead;
        logic                   memWrite;
        logic                   regWrite;
    } exMemT;

endpackage

`default_nettype wire

/* design/isaPkg.sv */
`default_nettype none

package isaPkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opcOp     = 7'b0110011,
        opcOpImm  = 7'b0010011,
        opcLui    = 7'b0110111,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcBranch = 7'b1100011,
        opcJal    = 7'b1101111
    } opcodeT;

    // funct3 codes
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;
    localparam logic [2:0] f3Word   = 3'b010;   // lw / sw

    // funct7 codes for R-type
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Sub  = 7'b0100000;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluPassB
    } aluOpT;

    typedef enum logic {wbAlu, wbLoad} wbSelT;

endpackage

`default_nettype wire

/* design/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath and register index widths
`define XLEN        32
`define REG_ADDR_W  5

// First fetch address after reset
`define RESET_PC    32'h0000_0000

// addi x0,x0,0
`define NOP_INSTR   32'h0000_0013

`endif
